// File: design/elink_cfg_config.svh
// word offsets index mi_addr[ELCFG_RFAW+1:2] and are sized for ELCFG_RFAW of 5; higher bits alias
`ifndef ELINK_CFG_CONFIG_SVH
`define ELINK_CFG_CONFIG_SVH

// ####################
// address decode
// ####################
`define ELCFG_RFAW 5                    // 32 word slots

`define ELRESET    5'd0                 // soft reset, bit 0
`define ELCLK      5'd1                 // clock settings, 16 bits
`define ELTX       5'd2                 // tx control, 9 bits
`define ELRX       5'd3                 // rx control, 5 bits
`define ELCOREID   5'd4                 // core id, 12 bits
`define ELVERSION  5'd5
`define ELDATAIN   5'd6                 // read only, sampled pins
`define ELDATAOUT  5'd7                 // gpio pin image
`define ELDEBUG    5'd8                 // sticky low byte, live upper bits
`define ELMBOXWR   5'd9                 // write only, mailbox push
`define ELMBOXRD   5'd10                // read only, mailbox pop

// ####################
// reset values
// ####################
`define ELCFG_DEFAULT_COREID  12'h808
`define ELCFG_DEFAULT_VERSION 16'h0000

// ####################
// mailbox
// ####################
`define EMBOX_DEPTH 4                   // entries, any value >= 1

`endif

// File: design/elink_cfg_pkg.sv
// plain vector types only; bit layouts inside pin_data_t are by convention, not by struct
package elink_cfg_pkg;

   // ####################
   // mi port
   // ####################
   typedef logic [19:0] mi_addr_t;      // full physical byte address
   typedef logic [31:0] mi_data_t;      // always whole words

   // ####################
   // link control
   // ####################
   typedef logic [11:0] coreid_t;       // core id of the fpga side
   typedef logic [15:0] clk_settings_t; // exported as is
   typedef logic [3:0]  ctrlmode_t;     // emesh ctrlmode tag

   // ####################
   // pins
   // ####################
   // [8:0]  frame and data lines
   // [10:9] the two wait lines
   typedef logic [10:0] pin_data_t;

endpackage

// File: design/ecfg.sv
// decodes mi_addr[6:2] only so upper bits alias; reads land one cycle late, no handshake
`timescale 1ns/1ns
`include "elink_cfg_config.svh"

module ecfg (
   input  logic                          mi_clk,
   input  logic                          hard_reset,          // only reset of the register file
   input  logic                          mi_en,
   input  logic                          mi_we,               // whole word writes only
   input  elink_cfg_pkg::mi_addr_t       mi_addr,             // byte address, not shifted
   input  elink_cfg_pkg::mi_data_t       mi_din,
   input  elink_cfg_pkg::pin_data_t      pins_sampled,        // already two flops deep
   input  logic [15:0]                   ecfg_tx_debug,
   input  logic [15:0]                   ecfg_rx_debug,
   input  elink_cfg_pkg::mi_data_t       embox_head,
   input  logic                          embox_not_empty,
   input  logic                          embox_full,
   output elink_cfg_pkg::mi_data_t       mi_dout,
   output logic                          soft_reset,
   output logic                          ecfg_tx_enable,
   output logic                          ecfg_tx_mmu_enable,
   output logic                          ecfg_tx_gpio_enable, // tx pins from dataout
   output elink_cfg_pkg::ctrlmode_t      ecfg_tx_ctrlmode,
   output logic                          ecfg_timeout_enable,
   output logic                          ecfg_rx_enable,
   output logic                          ecfg_rx_mmu_enable,
   output logic                          ecfg_rx_gpio_enable, // wait pins from dataout
   output elink_cfg_pkg::clk_settings_t  ecfg_clk_settings,
   output elink_cfg_pkg::coreid_t        ecfg_coreid,
   output elink_cfg_pkg::pin_data_t      ecfg_dataout,
   output logic                          embox_push,
   output logic                          embox_pop
);

   localparam int RFAW = `ELCFG_RFAW;

   logic [RFAW-1:0]                reg_sel;      // word offset
   logic                           cfg_write;
   logic                           cfg_read;
   logic                           reset_write;
   logic                           clk_write;
   logic                           tx_write;
   logic                           rx_write;
   logic                           coreid_write;
   logic                           version_write;
   logic                           dataout_write;

   logic                           reset_reg;
   logic [8:0]                     tx_reg;
   logic [4:0]                     rx_reg;
   elink_cfg_pkg::clk_settings_t   clk_reg;
   elink_cfg_pkg::coreid_t         coreid_reg;
   logic [15:0]                    version_reg;
   elink_cfg_pkg::pin_data_t       dataout_reg;
   elink_cfg_pkg::pin_data_t       datain_reg;
   logic [7:0]                     debug_reg;    // sticky bits
   elink_cfg_pkg::mi_data_t        debug_vector;

   // ####################
   // decode
   // ####################
   assign reg_sel   = mi_addr[RFAW+1:2];
   assign cfg_write = mi_en & mi_we;
   assign cfg_read  = mi_en & ~mi_we;

   assign reset_write   = cfg_write & (reg_sel == `ELRESET);
   assign clk_write     = cfg_write & (reg_sel == `ELCLK);
   assign tx_write      = cfg_write & (reg_sel == `ELTX);
   assign rx_write      = cfg_write & (reg_sel == `ELRX);
   assign coreid_write  = cfg_write & (reg_sel == `ELCOREID);
   assign version_write = cfg_write & (reg_sel == `ELVERSION);
   assign dataout_write = cfg_write & (reg_sel == `ELDATAOUT);

   // mailbox strobes, embox decides if they take effect
   assign embox_push = cfg_write & (reg_sel == `ELMBOXWR);
   assign embox_pop  = cfg_read & (reg_sel == `ELMBOXRD);

   // ####################
   // control registers
   // ####################
   always_ff @(posedge mi_clk) begin
      if (hard_reset) begin
         reset_reg   <= 1'b0;
         tx_reg      <= '0;
         rx_reg      <= '0;
         clk_reg     <= '0;
         coreid_reg  <= `ELCFG_DEFAULT_COREID;
         version_reg <= `ELCFG_DEFAULT_VERSION;
         dataout_reg <= '0;
      end else begin
         if (reset_write) begin
            reset_reg <= mi_din[0];
         end
         if (tx_write) begin
            tx_reg <= mi_din[8:0];
         end
         if (rx_write) begin
            rx_reg <= mi_din[4:0];
         end
         if (clk_write) begin
            clk_reg <= mi_din[15:0];
         end
         if (coreid_write) begin
            coreid_reg <= mi_din[11:0];
         end
         if (version_write) begin
            version_reg <= mi_din[15:0];
         end
         if (dataout_write) begin
            dataout_reg <= mi_din[10:0];
         end
      end
   end

   assign soft_reset          = reset_reg;
   assign ecfg_tx_enable      = tx_reg[0];
   assign ecfg_tx_mmu_enable  = tx_reg[1];
   assign ecfg_tx_gpio_enable = (tx_reg[3:2] == 2'b01);   // other codes reserved
   assign ecfg_tx_ctrlmode    = tx_reg[7:4];
   assign ecfg_timeout_enable = tx_reg[8];
   assign ecfg_rx_enable      = rx_reg[0];
   assign ecfg_rx_mmu_enable  = rx_reg[1];
   assign ecfg_rx_gpio_enable = (rx_reg[3:2] == 2'b01);
   assign ecfg_clk_settings   = clk_reg;
   assign ecfg_coreid         = coreid_reg;
   assign ecfg_dataout        = dataout_reg;

   // ####################
   // datain and debug
   // ####################
   // third flop on the pins, DATAIN trails the pins by 3 edges
   always_ff @(posedge mi_clk) begin
      if (hard_reset) begin
         datain_reg <= '0;
      end else begin
         datain_reg <= pins_sampled;
      end
   end

   // low byte {not_empty, rx[2:0], tx[2:0], full}, upper 24 bits live
   assign debug_vector = {ecfg_rx_debug[14:3],
                          ecfg_tx_debug[14:3],
                          embox_not_empty,
                          ecfg_rx_debug[2:0],
                          ecfg_tx_debug[2:0],
                          embox_full};

   always_ff @(posedge mi_clk) begin
      if (hard_reset) begin
         debug_reg <= '0;
      end else begin
         debug_reg <= debug_reg | debug_vector[7:0];   // soft reset leaves it alone
      end
   end

   // ####################
   // readback
   // ####################
   // held between reads
   always_ff @(posedge mi_clk) begin
      if (cfg_read) begin
         case (reg_sel)
            `ELRESET:   mi_dout <= {31'b0, reset_reg};
            `ELCLK:     mi_dout <= {16'b0, clk_reg};
            `ELTX:      mi_dout <= {23'b0, tx_reg};
            `ELRX:      mi_dout <= {27'b0, rx_reg};
            `ELCOREID:  mi_dout <= {20'b0, coreid_reg};
            `ELVERSION: mi_dout <= {16'b0, version_reg};
            `ELDATAIN:  mi_dout <= {21'b0, datain_reg};
            `ELDATAOUT: mi_dout <= {21'b0, dataout_reg};
            `ELDEBUG:   mi_dout <= {debug_vector[31:8], debug_reg};
            `ELMBOXRD:  mi_dout <= embox_head;   // zero when empty, popped this edge
            default:    mi_dout <= '0;
         endcase
      end
   end

   // at most one register or mailbox strobe per access
   a_strobe_onehot: assert property (@(posedge mi_clk) disable iff (hard_reset)
      $onehot0({reset_write, clk_write, tx_write, rx_write, coreid_write,
                version_write, dataout_write, embox_push, embox_pop}))
      else $error("ecfg: more than one strobe decoded");

endmodule

// File: design/embox.sv
// push while full and pop while empty are dropped; a push with a pop on a full box is lost
`timescale 1ns/1ns
`include "elink_cfg_config.svh"

module embox (
   input  logic                     mi_clk,
   input  logic                     hard_reset,
   input  logic                     embox_push,       // single cycle strobe
   input  logic                     embox_pop,        // single cycle strobe
   input  elink_cfg_pkg::mi_data_t  mi_din,
   output elink_cfg_pkg::mi_data_t  embox_head,       // oldest word, 0 when empty
   output logic                     embox_not_empty,  // interrupt source
   output logic                     embox_full
);

   localparam int DEPTH = `EMBOX_DEPTH;
   localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW    = $clog2(DEPTH + 1);

   elink_cfg_pkg::mi_data_t  mem [DEPTH];
   logic [PW-1:0]            wr_ptr;
   logic [PW-1:0]            rd_ptr;
   logic [CW-1:0]            count;       // occupancy
   logic                     do_push;
   logic                     do_pop;

   // wrap at DEPTH, works for depths that are not a power of two
   function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
      if (ptr == PW'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // ####################
   // flags
   // ####################
   assign embox_not_empty = (count != '0);
   assign embox_full      = (count == CW'(DEPTH));

   assign do_push = embox_push & ~embox_full;      // drop when full
   assign do_pop  = embox_pop & embox_not_empty;   // no-op when empty

   assign embox_head = embox_not_empty ? mem[rd_ptr] : '0;

   // ####################
   // pointers and count
   // ####################
   always_ff @(posedge mi_clk) begin
      if (hard_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
      end
   end

   // storage
   always_ff @(posedge mi_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= mi_din;
      end
   end

   // ####################
   // checks
   // ####################
   a_count_bound: assert property (@(posedge mi_clk) disable iff (hard_reset)
      count <= CW'(DEPTH))
      else $error("embox: count above depth");

endmodule

// File: design/elink_pin_ctrl.sv
// override mux is combinational; incoming pins are async and take two mi_clk edges to pins_sampled
`timescale 1ns/1ns

module elink_pin_ctrl (
   input  logic                      mi_clk,
   input  logic                      hard_reset,
   input  logic                      ecfg_tx_gpio_enable,
   input  logic                      ecfg_rx_gpio_enable,
   input  elink_cfg_pkg::pin_data_t  ecfg_dataout,    // gpio pin image
   input  logic [8:0]                link_tx_pins,    // from the transmitter
   input  logic [1:0]                link_rx_wait,    // from the receiver
   input  logic [8:0]                pin_rx,          // frame and data in
   input  logic [1:0]                pin_tx_wait,     // wait lines in
   output logic [8:0]                pin_tx,
   output logic [1:0]                pin_rx_wait,
   output elink_cfg_pkg::pin_data_t  pins_sampled     // {tx wait, rx pins}
);

   elink_cfg_pkg::pin_data_t pin_meta;   // first sync stage

   // ####################
   // outgoing override
   // ####################
   assign pin_tx      = ecfg_tx_gpio_enable ? ecfg_dataout[8:0] : link_tx_pins;
   assign pin_rx_wait = ecfg_rx_gpio_enable ? ecfg_dataout[10:9] : link_rx_wait;

   // ####################
   // incoming sync
   // ####################
   always_ff @(posedge mi_clk) begin
      if (hard_reset) begin
         pin_meta     <= '0;
         pins_sampled <= '0;
      end else begin
         pin_meta     <= {pin_tx_wait, pin_rx};   // same layout as dataout
         pins_sampled <= pin_meta;
      end
   end

   // pins leave the chip, no x once out of reset
   a_pins_known: assert property (@(posedge mi_clk) disable iff (hard_reset)
      !$isunknown({pin_tx, pin_rx_wait}))
      else $error("elink_pin_ctrl: unknown value on outgoing pins");

endmodule

// File: design/elink_cfg_top.sv
// mi port allows one access per cycle with no back-pressure; mailbox flags are exported as interrupts
`timescale 1ns/1ns

module elink_cfg_top (
   input  logic                          mi_clk,
   input  logic                          hard_reset,
   input  logic                          mi_en,
   input  logic                          mi_we,
   input  elink_cfg_pkg::mi_addr_t       mi_addr,
   input  elink_cfg_pkg::mi_data_t       mi_din,
   output elink_cfg_pkg::mi_data_t       mi_dout,
   output logic                          soft_reset,
   output logic                          ecfg_tx_enable,
   output logic                          ecfg_tx_mmu_enable,
   output logic                          ecfg_tx_gpio_enable,
   output elink_cfg_pkg::ctrlmode_t      ecfg_tx_ctrlmode,
   output logic                          ecfg_timeout_enable,
   output logic                          ecfg_rx_enable,
   output logic                          ecfg_rx_mmu_enable,
   output logic                          ecfg_rx_gpio_enable,
   output elink_cfg_pkg::clk_settings_t  ecfg_clk_settings,
   output elink_cfg_pkg::coreid_t        ecfg_coreid,
   input  logic [15:0]                   ecfg_tx_debug,
   input  logic [15:0]                   ecfg_rx_debug,
   output logic                          embox_not_empty,
   output logic                          embox_full,
   input  logic [8:0]                    link_tx_pins,
   input  logic [1:0]                    link_rx_wait,
   input  logic [8:0]                    pin_rx,
   input  logic [1:0]                    pin_tx_wait,
   output logic [8:0]                    pin_tx,
   output logic [1:0]                    pin_rx_wait
);

   elink_cfg_pkg::pin_data_t  ecfg_dataout;   // gpio image to pin mux
   elink_cfg_pkg::pin_data_t  pins_sampled;   // synced pins to DATAIN
   elink_cfg_pkg::mi_data_t   embox_head;
   logic                      embox_push;
   logic                      embox_pop;

   // ####################
   // register file
   // ####################
   ecfg u_ecfg (
      .mi_clk              (mi_clk),
      .hard_reset          (hard_reset),
      .mi_en               (mi_en),
      .mi_we               (mi_we),
      .mi_addr             (mi_addr),
      .mi_din              (mi_din),
      .pins_sampled        (pins_sampled),
      .ecfg_tx_debug       (ecfg_tx_debug),
      .ecfg_rx_debug       (ecfg_rx_debug),
      .embox_head          (embox_head),
      .embox_not_empty     (embox_not_empty),
      .embox_full          (embox_full),
      .mi_dout             (mi_dout),
      .soft_reset          (soft_reset),
      .ecfg_tx_enable      (ecfg_tx_enable),
      .ecfg_tx_mmu_enable  (ecfg_tx_mmu_enable),
      .ecfg_tx_gpio_enable (ecfg_tx_gpio_enable),
      .ecfg_tx_ctrlmode    (ecfg_tx_ctrlmode),
      .ecfg_timeout_enable (ecfg_timeout_enable),
      .ecfg_rx_enable      (ecfg_rx_enable),
      .ecfg_rx_mmu_enable  (ecfg_rx_mmu_enable),
      .ecfg_rx_gpio_enable (ecfg_rx_gpio_enable),
      .ecfg_clk_settings   (ecfg_clk_settings),
      .ecfg_coreid         (ecfg_coreid),
      .ecfg_dataout        (ecfg_dataout),
      .embox_push          (embox_push),
      .embox_pop           (embox_pop)
   );

   // ####################
   // mailbox
   // ####################
   embox u_embox (
      .mi_clk          (mi_clk),
      .hard_reset      (hard_reset),
      .embox_push      (embox_push),
      .embox_pop       (embox_pop),
      .mi_din          (mi_din),
      .embox_head      (embox_head),
      .embox_not_empty (embox_not_empty),
      .embox_full      (embox_full)
   );

   // ####################
   // pins
   // ####################
   elink_pin_ctrl u_pin_ctrl (
      .mi_clk              (mi_clk),
      .hard_reset          (hard_reset),
      .ecfg_tx_gpio_enable (ecfg_tx_gpio_enable),
      .ecfg_rx_gpio_enable (ecfg_rx_gpio_enable),
      .ecfg_dataout        (ecfg_dataout),
      .link_tx_pins        (link_tx_pins),
      .link_rx_wait        (link_rx_wait),
      .pin_rx              (pin_rx),
      .pin_tx_wait         (pin_tx_wait),
      .pin_tx              (pin_tx),
      .pin_rx_wait         (pin_rx_wait),
      .pins_sampled        (pins_sampled)
   );

endmodule

// File: sim/tb_clock.sv
// free running clock from time 0; hard_reset is high for the first RESET_CYCLES edges or while extra_reset is high
`timescale 1ns/1ns

module tb_clock #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 2
) (
   input  logic extra_reset,   // later resets, driven by the testbench
   output logic mi_clk,
   output logic hard_reset
);

   logic por;   // power-on part

   initial begin
      mi_clk = 1'b0;
      forever #(PERIOD_NS / 2) mi_clk = ~mi_clk;
   end

   // release 1 ns after the last reset edge, same as other inputs
   initial begin
      por = 1'b1;
      repeat (RESET_CYCLES) @(posedge mi_clk);
      #1;
      por = 1'b0;
   end

   assign hard_reset = por | extra_reset;

endmodule

// File: sim/elink_cfg_tb.sv
// inputs change 1 ns after the rising edge; the run stops at the first mismatch
`timescale 1ns/1ns
`include "elink_cfg_config.svh"

module elink_cfg_tb;

   localparam int CLK_PERIOD_NS    = 8;
   localparam int FIELD_ROUNDS     = 20;
   localparam int PLANNED_ACCESSES = 420;   // about 330 accesses and idle cycles, rounded up
   localparam int TIMEOUT_NS       = (PLANNED_ACCESSES * 10 + 200) * CLK_PERIOD_NS;

   logic                          mi_clk;
   logic                          hard_reset;
   logic                          extra_reset;
   logic                          mi_en;
   logic                          mi_we;
   elink_cfg_pkg::mi_addr_t       mi_addr;
   elink_cfg_pkg::mi_data_t       mi_din;
   elink_cfg_pkg::mi_data_t       mi_dout;
   logic                          soft_reset;
   logic                          ecfg_tx_enable;
   logic                          ecfg_tx_mmu_enable;
   logic                          ecfg_tx_gpio_enable;
   elink_cfg_pkg::ctrlmode_t      ecfg_tx_ctrlmode;
   logic                          ecfg_timeout_enable;
   logic                          ecfg_rx_enable;
   logic                          ecfg_rx_mmu_enable;
   logic                          ecfg_rx_gpio_enable;
   elink_cfg_pkg::clk_settings_t  ecfg_clk_settings;
   elink_cfg_pkg::coreid_t        ecfg_coreid;
   logic [15:0]                   ecfg_tx_debug;
   logic [15:0]                   ecfg_rx_debug;
   logic                          embox_not_empty;
   logic                          embox_full;
   logic [8:0]                    link_tx_pins;
   logic [1:0]                    link_rx_wait;
   logic [8:0]                    pin_rx;
   logic [1:0]                    pin_tx_wait;
   logic [8:0]                    pin_tx;
   logic [1:0]                    pin_rx_wait;

   // ####################
   // reference model state
   // ####################
   logic                m_reset;
   logic [15:0]         m_clk;
   logic [8:0]          m_tx;
   logic [4:0]          m_rx;
   logic [11:0]         m_coreid;
   logic [15:0]         m_version;
   logic [10:0]         m_dataout;
   logic [7:0]          m_sticky;      // debug low byte
   logic [31:0]         m_box[$];      // mailbox contents, head first
   logic [31:0]         exp_q[$];      // expected readback, one per read
   string               name_q[$];
   logic                read_seen;     // a read was sampled at the last edge
   logic [15:0]         lfsr_state = 16'd42573;
   logic [4:0]          rw_offsets [6] = '{`ELRESET, `ELCLK, `ELTX, `ELRX, `ELCOREID, `ELDATAOUT};

   tb_clock #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(2)) u_clock (
      .extra_reset (extra_reset),
      .mi_clk      (mi_clk),
      .hard_reset  (hard_reset)
   );

   elink_cfg_top u_elink_cfg_top (.*);

   // ####################
   // helpers
   // ####################
   // 16 bit galois, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 16'hB400;
      end
      return n;
   endfunction

   task automatic random_bits(input int nbits, output logic [31:0] value);
      value = 32'h0;
      for (int i = 0; i < nbits; i++) begin
         value = {value[30:0], lfsr_state[0]};   // one step per bit
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Fail %s: got %h, expected %h", name, actual, expected);
         $display("TB FAILED");
         $fatal(1);
      end
   endtask

   task automatic model_reset();
      m_reset   = 1'b0;
      m_clk     = 16'h0;
      m_tx      = 9'h0;
      m_rx      = 5'h0;
      m_coreid  = 12'h808;    // link default id
      m_version = 16'h0;
      m_dataout = 11'h0;
      m_box.delete();
   endtask

   task automatic model_write(input logic [4:0] offset, input logic [31:0] data);
      case (offset)
         `ELRESET:   m_reset   = data[0];
         `ELCLK:     m_clk     = data[15:0];
         `ELTX:      m_tx      = data[8:0];
         `ELRX:      m_rx      = data[4:0];
         `ELCOREID:  m_coreid  = data[11:0];
         `ELVERSION: m_version = data[15:0];
         `ELDATAOUT: m_dataout = data[10:0];
         `ELMBOXWR: begin
            if (m_box.size() < `EMBOX_DEPTH) begin
               m_box.push_back(data);      // full mailbox drops it
            end
         end
         default: ;                        // unused, nothing stored
      endcase
   endtask

   // expected mi_dout for a read issued now
   function automatic logic [31:0] expected_read(input logic [4:0] offset);
      case (offset)
         `ELRESET:   return {31'h0, m_reset};
         `ELCLK:     return {16'h0, m_clk};
         `ELTX:      return {23'h0, m_tx};
         `ELRX:      return {27'h0, m_rx};
         `ELCOREID:  return {20'h0, m_coreid};
         `ELVERSION: return {16'h0, m_version};
         `ELDATAIN:  return {21'h0, pin_tx_wait, pin_rx};   // pins held still
         `ELDATAOUT: return {21'h0, m_dataout};
         `ELDEBUG:   return {ecfg_rx_debug[14:3], ecfg_tx_debug[14:3], m_sticky};
         `ELMBOXRD:  return (m_box.size() == 0) ? 32'h0 : m_box[0];
         default:    return 32'h0;
      endcase
   endfunction

   // sticky byte tracks flags from the model count
   always @(posedge mi_clk) begin
      if (hard_reset) begin
         m_sticky <= 8'h0;
      end else begin
         m_sticky <= m_sticky | {m_box.size() != 0, ecfg_rx_debug[2:0],
                                 ecfg_tx_debug[2:0], m_box.size() == `EMBOX_DEPTH};
      end
   end

   // ####################
   // mi access
   // ####################
   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge mi_clk);
         #1;
      end
   endtask

   task automatic mi_write(input logic [4:0] offset, input logic [31:0] data);
      mi_en   = 1'b1;
      mi_we   = 1'b1;
      mi_addr = {13'h0, offset, 2'b00};
      mi_din  = data;
      idle_cycles(1);
      mi_en   = 1'b0;
      mi_we   = 1'b0;
      model_write(offset, data);   // DUT took it at that edge
   endtask

   task automatic mi_read(input logic [4:0] offset);
      exp_q.push_back(expected_read(offset));
      name_q.push_back($sformatf("mi_dout @ offset %0d", offset));
      mi_en   = 1'b1;
      mi_we   = 1'b0;
      mi_addr = {13'h0, offset, 2'b00};
      idle_cycles(1);
      mi_en   = 1'b0;
      if (offset == `ELMBOXRD && m_box.size() != 0) begin
         void'(m_box.pop_front());   // popped on the read edge
      end
   endtask

   task automatic apply_reset();
      extra_reset = 1'b1;
      model_reset();
      idle_cycles(2);
      extra_reset = 1'b0;
   endtask

   task automatic pulse_debug(input logic [15:0] tx_bits, input logic [15:0] rx_bits);
      ecfg_tx_debug = tx_bits;
      ecfg_rx_debug = rx_bits;
      idle_cycles(1);              // one edge only
      ecfg_tx_debug = 16'h0;
      ecfg_rx_debug = 16'h0;
   endtask

   // control levels and pin mux against the field rules
   task automatic check_outputs();
      logic tx_gpio;
      logic rx_gpio;
      tx_gpio = (m_tx[3:2] == 2'b01);
      rx_gpio = (m_rx[3:2] == 2'b01);
      check_value("soft_reset", 32'(soft_reset), 32'(m_reset));
      check_value("ecfg_tx_enable", 32'(ecfg_tx_enable), 32'(m_tx[0]));
      check_value("ecfg_tx_mmu_enable", 32'(ecfg_tx_mmu_enable), 32'(m_tx[1]));
      check_value("ecfg_tx_gpio_enable", 32'(ecfg_tx_gpio_enable), 32'(tx_gpio));
      check_value("ecfg_tx_ctrlmode", 32'(ecfg_tx_ctrlmode), 32'(m_tx[7:4]));
      check_value("ecfg_timeout_enable", 32'(ecfg_timeout_enable), 32'(m_tx[8]));
      check_value("ecfg_rx_enable", 32'(ecfg_rx_enable), 32'(m_rx[0]));
      check_value("ecfg_rx_mmu_enable", 32'(ecfg_rx_mmu_enable), 32'(m_rx[1]));
      check_value("ecfg_rx_gpio_enable", 32'(ecfg_rx_gpio_enable), 32'(rx_gpio));
      check_value("ecfg_clk_settings", 32'(ecfg_clk_settings), 32'(m_clk));
      check_value("ecfg_coreid", 32'(ecfg_coreid), 32'(m_coreid));
      check_value("pin_tx", 32'(pin_tx), 32'(tx_gpio ? m_dataout[8:0] : link_tx_pins));
      check_value("pin_rx_wait", 32'(pin_rx_wait),
                  32'(rx_gpio ? m_dataout[10:9] : link_rx_wait));
      check_value("embox_not_empty", 32'(embox_not_empty), 32'(m_box.size() != 0));
      check_value("embox_full", 32'(embox_full), 32'(m_box.size() == `EMBOX_DEPTH));
   endtask

   // ####################
   // readback compare
   // ####################
   always @(posedge mi_clk) begin
      read_seen <= mi_en & ~mi_we & ~hard_reset;
   end

   // mi_dout is settled by the falling edge
   always @(negedge mi_clk) begin
      if (read_seen) begin
         if (exp_q.size() == 0) begin
            $display("a read completed with no expected value queued");
            $display("TB FAILED");
            $fatal(1);
         end else begin
            check_value(name_q.pop_front(), mi_dout, exp_q.pop_front());
         end
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("watchdog expired, run took longer than %0d ns", TIMEOUT_NS);
      $display("TB FAILED");
      $fatal(1);
   end

   // ####################
   // stimulus
   // ####################
   initial begin
      logic [31:0] word;
      logic [31:0] pins;
      extra_reset   = 1'b0;
      mi_en         = 1'b0;
      mi_we         = 1'b0;
      mi_addr       = '0;
      mi_din        = '0;
      ecfg_tx_debug = 16'h0;
      ecfg_rx_debug = 16'h0;
      link_tx_pins  = 9'h0;
      link_rx_wait  = 2'h0;
      pin_rx        = 9'h0;
      pin_tx_wait   = 2'h0;
      model_reset();
      wait (hard_reset === 1'b1);
      wait (hard_reset === 1'b0);   // lands 1 ns past an edge

      // reset values, offsets 0..10 plus two unused
      check_outputs();
      for (int k = 0; k <= 10; k++) begin
         mi_read(5'(k));
      end
      mi_read(5'd11);
      mi_read(5'd31);

      // register fields, random data
      for (int r = 0; r < FIELD_ROUNDS; r++) begin
         for (int k = 0; k < 6; k++) begin
            random_bits(32, word);
            mi_write(rw_offsets[k], word);
            check_outputs();
            mi_read(rw_offsets[k]);
         end
      end
      for (int code = 0; code < 4; code++) begin   // every gpio mode code
         random_bits(32, word);
         word[3:2] = 2'(code);
         mi_write(`ELTX, word);
         check_outputs();
         mi_write(`ELRX, word);
         check_outputs();
      end
      // unused offsets store nothing and read 0
      random_bits(32, word);
      mi_write(5'd20, word);
      mi_write(5'd31, ~word);
      check_outputs();
      mi_read(5'd20);
      mi_read(5'd31);
      mi_read(`ELMBOXWR);           // write only
      for (int k = 0; k < 6; k++) begin
         mi_read(rw_offsets[k]);
      end

      // pin override
      mi_write(`ELTX, 32'h0);
      mi_write(`ELRX, 32'h0);
      random_bits(11, pins);
      link_tx_pins = pins[8:0];
      link_rx_wait = pins[10:9];
      idle_cycles(1);
      check_outputs();              // links pass through
      random_bits(11, word);
      mi_write(`ELDATAOUT, word);
      check_outputs();
      mi_write(`ELTX, 32'h0000_0054);   // gpio 01, ctrlmode 5
      check_outputs();
      mi_write(`ELRX, 32'h0000_0004);
      check_outputs();
      random_bits(11, pins);
      link_tx_pins = pins[8:0];
      link_rx_wait = pins[10:9];
      idle_cycles(1);
      check_outputs();              // still dataout
      mi_write(`ELTX, 32'h0000_000c);   // code 11, override off
      mi_write(`ELRX, 32'h0000_000c);
      check_outputs();
      for (int n = 0; n < 3; n++) begin
         random_bits(11, pins);
         pin_rx      = pins[8:0];
         pin_tx_wait = pins[10:9];
         idle_cycles(5);            // past the 3 flop path
         mi_read(`ELDATAIN);
      end

      // mailbox, the fifth word is dropped
      for (int n = 0; n < 5; n++) begin
         random_bits(32, word);
         mi_write(`ELMBOXWR, word);
         check_outputs();
      end
      for (int n = 0; n < 5; n++) begin
         mi_read(`ELMBOXRD);        // last one empty
         check_outputs();
      end

      // sticky debug
      for (int b = 0; b < 3; b++) begin
         pulse_debug(16'(1 << b), 16'h0);
         pulse_debug(16'h0, 16'(1 << b));
         idle_cycles(1);
         mi_read(`ELDEBUG);
      end
      random_bits(16, word);
      ecfg_tx_debug = word[15:0] & 16'hfff8;   // live bits only
      random_bits(16, word);
      ecfg_rx_debug = word[15:0] & 16'hfff8;
      idle_cycles(1);
      mi_read(`ELDEBUG);
      mi_write(`ELRESET, 32'h1);    // soft reset keeps the byte
      check_outputs();
      mi_read(`ELDEBUG);
      apply_reset();
      idle_cycles(1);
      check_outputs();
      mi_read(`ELDEBUG);
      for (int k = 0; k < 6; k++) begin
         mi_read(rw_offsets[k]);
      end

      idle_cycles(2);               // let the last compare run
      if (exp_q.size() != 0) begin
         $display("%0d reads never returned data", exp_q.size());
         $display("TB FAILED");
         $fatal(1);
      end else begin
         $display("TB PASSED");
         $finish;
      end
   end

endmodule

// File: elink_cfg.f
+incdir+design
design/elink_cfg_pkg.sv
design/ecfg.sv
design/embox.sv
design/elink_pin_ctrl.sv
design/elink_cfg_top.sv
sim/tb_clock.sv
sim/elink_cfg_tb.sv

// File: Makefile
# Verilator flow for the elink config block
TOP := elink_cfg_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -sv --top-module $(TOP) -f elink_cfg.f

sim:
	verilator --binary --timing --assert -sv -Wno-fatal --top-module $(TOP) \
		-f elink_cfg.f -Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
